//--- design/emu_pkg.sv
package emu_pkg;

    // target program counter and scan chain length
    localparam int PC_WIDTH = 32;

    // tick counter and step counter
    localparam int CNT_WIDTH = 64;

    // host cycles per target tick
    localparam int TICK_DIV = 4;
    localparam int DIV_WIDTH = $clog2(TICK_DIV);

    // console buffer depth, equal to the number of credits at reset
    localparam int CONSOLE_DEPTH = 4;
    localparam int PTR_WIDTH = $clog2(CONSOLE_DEPTH);

    // must be able to hold CONSOLE_DEPTH itself
    localparam int CREDIT_WIDTH = 3;

    localparam int CHAR_WIDTH = 8;

    // a character goes out when the low bits of the new pc are zero
    localparam int CHAR_PERIOD_LOG2 = 3;

    // the character is taken from the pc just above the period bits
    localparam int CHAR_LSB = CHAR_PERIOD_LOG2;

endpackage

//--- design/tick_gen.sv
`timescale 1ns/100ps

module tick_gen
    import emu_pkg::*;
(
    input  logic host_clk,
    input  logic host_rst,
    input  logic run_mode,
    input  logic target_ready,
    output logic tick
);

    localparam logic [DIV_WIDTH-1:0] DIV_LAST = DIV_WIDTH'(TICK_DIV - 1);

    logic [DIV_WIDTH-1:0] div;
    logic                 div_done;

    assign div_done = (div == DIV_LAST);

    // one target cycle per TICK_DIV host cycles, held off by back-pressure
    assign tick = div_done && target_ready;

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            div <= '0;
        end else if (!run_mode) begin
            // restart the period from zero on the next resume
            div <= '0;
        end else if (div_done) begin
            if (target_ready) begin
                div <= '0;
            end
        end else begin
            div <= div + 1'b1;
        end
    end

endmodule

//--- design/run_ctrl.sv
`timescale 1ns/100ps

module run_ctrl
    import emu_pkg::*;
(
    input  logic                 host_clk,
    input  logic                 host_rst,

    input  logic                 tick,
    input  logic                 trig,

    input  logic                 do_pause,
    input  logic                 do_resume,

    input  logic                 count_write,
    input  logic [CNT_WIDTH-1:0] count_wdata,

    input  logic                 step_write,
    input  logic [CNT_WIDTH-1:0] step_wdata,

    output logic [CNT_WIDTH-1:0] count,
    output logic                 step_trig,
    output logic                 run_mode
);

    logic [CNT_WIDTH-1:0] step;
    logic [CNT_WIDTH-1:0] step_next;
    logic                 advance;

    assign advance = run_mode && tick;

    // free-running target cycle count, host may overwrite it
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            count <= '0;
        end else if (count_write) begin
            count <= count_wdata;
        end else if (advance) begin
            count <= count + 1'b1;
        end
    end

    // step budget, zero means no limit
    always_comb begin
        if (step_write) begin
            step_next = step_wdata;
        end else if (step == '0) begin
            step_next = '0;
        end else if (advance) begin
            step_next = step - 1'b1;
        end else begin
            step_next = step;
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            step <= '0;
        end else begin
            step <= step_next;
        end
    end

    assign step_trig = (step != '0) && (step_next == '0);

    // stop requests only take effect on a tick, so the target halts on a cycle boundary
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            run_mode <= 1'b1;
        end else if ((trig || step_trig || do_pause) && tick) begin
            run_mode <= 1'b0;
        end else if (do_resume) begin
            run_mode <= 1'b1;
        end
    end

endmodule

//--- design/target_core.sv
`timescale 1ns/100ps

module target_core
    import emu_pkg::*;
(
    input  logic                  host_clk,
    input  logic                  host_rst,

    input  logic                  tick,
    input  logic                  run_mode,

    input  logic                  bp_write,
    input  logic [PC_WIDTH-1:0]   bp_wdata,

    input  logic                  ff_scan,
    input  logic                  ff_dir,
    input  logic                  ff_sdi,

    input  logic                  credit_return,

    output logic                  trig,
    output logic                  target_ready,
    output logic                  ff_sdo,
    output logic                  char_push,
    output logic [CHAR_WIDTH-1:0] char_data,
    output logic                  idle
);

    logic [PC_WIDTH-1:0]     pc;
    logic [PC_WIDTH-1:0]     pc_next;
    logic [PC_WIDTH-1:0]     bp;
    logic                    bp_en;
    logic                    emit_next;
    logic                    emit;
    logic                    scan_in;
    logic [CREDIT_WIDTH-1:0] credits;

    assign pc_next = pc + 1'b1;
    assign emit_next = (pc_next[CHAR_PERIOD_LOG2-1:0] == '0);
    assign emit = tick && emit_next;

    // a step that prints needs a credit, any other step may always go
    assign target_ready = (credits != '0) || !emit_next;

    assign trig = tick && bp_en && (pc_next == bp);

    // rotate by default, so a full pass leaves the pc unchanged
    assign ff_sdo = pc[PC_WIDTH-1];
    assign scan_in = ff_dir ? ff_sdi : ff_sdo;

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            pc <= '0;
        end else if (ff_scan && !run_mode) begin
            pc <= {pc[PC_WIDTH-2:0], scan_in};
        end else if (tick) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            bp_en <= 1'b0;
        end else if (bp_write) begin
            bp_en <= 1'b1;
        end
    end

    always_ff @(posedge host_clk) begin
        if (bp_write) begin
            bp <= bp_wdata;
        end
    end

    // console sender
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            char_push <= 1'b0;
        end else begin
            char_push <= emit;
        end
    end

    always_ff @(posedge host_clk) begin
        if (emit) begin
            char_data <= pc_next[CHAR_LSB +: CHAR_WIDTH];
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            credits <= CREDIT_WIDTH'(CONSOLE_DEPTH);
        end else begin
            credits <= credits + CREDIT_WIDTH'(credit_return) - CREDIT_WIDTH'(emit);
        end
    end

    // quiet once stopped and every character has been taken by the host
    assign idle = !run_mode && (credits == CREDIT_WIDTH'(CONSOLE_DEPTH));

endmodule

//--- design/console_fifo.sv
`timescale 1ns/100ps

module console_fifo
    import emu_pkg::*;
(
    input  logic                  host_clk,
    input  logic                  host_rst,

    input  logic                  char_push,
    input  logic [CHAR_WIDTH-1:0] char_data,

    output logic                  console_valid,
    output logic [CHAR_WIDTH-1:0] console_data,
    input  logic                  console_ready,

    output logic                  credit_return
);

    logic [CHAR_WIDTH-1:0]   mem [CONSOLE_DEPTH];
    logic [PTR_WIDTH-1:0]    wr_ptr;
    logic [PTR_WIDTH-1:0]    rd_ptr;
    logic [CREDIT_WIDTH-1:0] fill;
    logic                    pop;

    assign console_valid = (fill != '0);
    assign console_data = mem[rd_ptr];
    assign pop = console_valid && console_ready;

    // the sender holds a credit for every push, so no full check here
    always_ff @(posedge host_clk) begin
        if (char_push) begin
            mem[wr_ptr] <= char_data;
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
        end else begin
            if (char_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            fill <= fill + CREDIT_WIDTH'(char_push) - CREDIT_WIDTH'(pop);
        end
    end

    // one credit back per character taken
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;
        end
    end

endmodule

//--- design/emu_top.sv
`timescale 1ns/100ps

module emu_top
    import emu_pkg::*;
(
    input  logic                  host_clk,
    input  logic                  host_rst,

    input  logic                  do_pause,
    input  logic                  do_resume,
    output logic                  run_mode,
    output logic                  idle,

    output logic                  trig,
    output logic                  step_trig,

    output logic [CNT_WIDTH-1:0]  count,
    input  logic                  count_write,
    input  logic [CNT_WIDTH-1:0]  count_wdata,

    input  logic                  step_write,
    input  logic [CNT_WIDTH-1:0]  step_wdata,

    input  logic                  bp_write,
    input  logic [PC_WIDTH-1:0]   bp_wdata,

    input  logic                  ff_scan,
    input  logic                  ff_dir,
    input  logic                  ff_sdi,
    output logic                  ff_sdo,

    output logic                  console_valid,
    output logic [CHAR_WIDTH-1:0] console_data,
    input  logic                  console_ready
);

    logic                  tick;
    logic                  target_ready;
    logic                  char_push;
    logic [CHAR_WIDTH-1:0] char_data;
    logic                  credit_return;

    tick_gen u_tick_gen (
        .host_clk     (host_clk),
        .host_rst     (host_rst),
        .run_mode     (run_mode),
        .target_ready (target_ready),
        .tick         (tick)
    );

    run_ctrl u_run_ctrl (
        .host_clk    (host_clk),
        .host_rst    (host_rst),
        .tick        (tick),
        .trig        (trig),
        .do_pause    (do_pause),
        .do_resume   (do_resume),
        .count_write (count_write),
        .count_wdata (count_wdata),
        .step_write  (step_write),
        .step_wdata  (step_wdata),
        .count       (count),
        .step_trig   (step_trig),
        .run_mode    (run_mode)
    );

    target_core u_target_core (
        .host_clk      (host_clk),
        .host_rst      (host_rst),
        .tick          (tick),
        .run_mode      (run_mode),
        .bp_write      (bp_write),
        .bp_wdata      (bp_wdata),
        .ff_scan       (ff_scan),
        .ff_dir        (ff_dir),
        .ff_sdi        (ff_sdi),
        .credit_return (credit_return),
        .trig          (trig),
        .target_ready  (target_ready),
        .ff_sdo        (ff_sdo),
        .char_push     (char_push),
        .char_data     (char_data),
        .idle          (idle)
    );

    console_fifo u_console_fifo (
        .host_clk      (host_clk),
        .host_rst      (host_rst),
        .char_push     (char_push),
        .char_data     (char_data),
        .console_valid (console_valid),
        .console_data  (console_data),
        .console_ready (console_ready),
        .credit_return (credit_return)
    );

endmodule

//--- dv/emu_asserts.sv
`timescale 1ns/100ps

module emu_asserts
    import emu_pkg::*;
(
    input logic                  host_clk,
    input logic                  host_rst,
    input logic                  run_mode,
    input logic                  tick,
    input logic                  ff_scan,
    input logic                  ff_sdo,
    input logic                  console_valid,
    input logic                  console_ready,
    input logic [CHAR_WIDTH-1:0] console_data
);

    int unsigned fails = 0;

    tick_only_running: assert property (@(posedge host_clk) disable iff (host_rst)
        tick |-> run_mode)
        else begin
            fails++;
            $error("tick while run_mode is low");
        end

    // a stalled character stays in place until the host takes it
    console_held: assert property (@(posedge host_clk) disable iff (host_rst)
        console_valid && !console_ready |=> console_valid && $stable(console_data))
        else begin
            fails++;
            $error("console character dropped or changed without a pop");
        end

    sdo_stable: assert property (@(posedge host_clk) disable iff (host_rst)
        !$stable(ff_sdo) |-> $past(ff_scan) || $past(tick))
        else begin
            fails++;
            $error("ff_sdo changed without scan or tick");
        end

endmodule

bind emu_top emu_asserts u_asserts (
    .host_clk      (host_clk),
    .host_rst      (host_rst),
    .run_mode      (run_mode),
    .tick          (tick),
    .ff_scan       (ff_scan),
    .ff_sdo        (ff_sdo),
    .console_valid (console_valid),
    .console_ready (console_ready),
    .console_data  (console_data)
);

//--- dv/emu_tb.sv
`timescale 1ns/100ps

module emu_tb
    import emu_pkg::*;
();

    localparam int UNTIL_RUN = 0;
    localparam int UNTIL_IDLE = 1;
    localparam int UNTIL_RX = 2;

    logic                  host_clk;
    logic                  host_rst;
    logic                  do_pause, do_resume, run_mode, idle;
    logic                  trig, step_trig;
    logic [CNT_WIDTH-1:0]  count, count_wdata, step_wdata;
    logic                  count_write, step_write, bp_write;
    logic [PC_WIDTH-1:0]   bp_wdata;
    logic                  ff_scan, ff_dir, ff_sdi, ff_sdo;
    logic                  console_valid, console_ready;
    logic [CHAR_WIDTH-1:0] console_data;

    // reference model state
    logic [63:0]           ticks_seen;
    logic [63:0]           rx_count;
    int                    step_pulses;
    int                    trig_pulses;
    logic [PC_WIDTH-1:0]   seq_base;
    logic [63:0]           seq_rx;
    logic [PC_WIDTH-1:0]   pc_offset;
    logic [PC_WIDTH-1:0]   bp_val;

    emu_top dut (.*);

    initial begin
        host_clk = 1'b0;
        forever #10 host_clk = ~host_clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: %s is 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    // pc of the next character the host should see
    function automatic logic [PC_WIDTH-1:0] next_char_pc();
        return seq_base + PC_WIDTH'((rx_count - seq_rx + 1) << CHAR_PERIOD_LOG2);
    endfunction

    always @(posedge host_clk) begin
        if (host_rst) begin
            ticks_seen = '0;
            rx_count = '0;
            step_pulses = 0;
            trig_pulses = 0;
        end else begin
            if (dut.tick) begin
                ticks_seen = ticks_seen + 1;
            end
            if (step_trig) begin
                step_pulses = step_pulses + 1;
            end
            if (trig) begin
                trig_pulses = trig_pulses + 1;
            end
            if (console_valid && console_ready) begin
                check_value("console_data", 64'(console_data),
                            64'(CHAR_WIDTH'(next_char_pc() >> CHAR_PERIOD_LOG2)));
                rx_count = rx_count + 1;
            end
        end
    end

    task automatic wait_for(input int what, input logic [63:0] val, input int limit);
        int  n;
        bit  done;
        n = 0;
        done = 1'b0;
        while (!done) begin
            case (what)
                UNTIL_RUN: done = (run_mode == val[0]);
                UNTIL_IDLE: done = idle;
                default: done = (rx_count >= val);
            endcase
            if (!done) begin
                if (n == limit) begin
                    abort_run($sformatf("timeout: condition %0d not reached in %0d cycles",
                                        what, limit));
                end
                @(posedge host_clk);
                n++;
            end
        end
    endtask

    task automatic pause_target();
        @(posedge host_clk);
        do_pause <= 1'b1;
        wait_for(UNTIL_RUN, 64'd0, 200);
        do_pause <= 1'b0;
    endtask

    task automatic resume_target();
        @(posedge host_clk);
        do_resume <= 1'b1;
        @(posedge host_clk);
        do_resume <= 1'b0;
        wait_for(UNTIL_RUN, 64'd1, 4);
    endtask

    // 32 shifts, msb first out, load bits go in msb first
    task automatic scan_pass(input logic dir, input logic [PC_WIDTH-1:0] load,
                             output logic [PC_WIDTH-1:0] got);
        @(posedge host_clk);
        ff_scan <= 1'b1;
        ff_dir <= dir;
        ff_sdi <= load[PC_WIDTH-1];
        for (int i = 0; i < PC_WIDTH; i++) begin
            @(posedge host_clk);
            got = {got[PC_WIDTH-2:0], ff_sdo};
            if (i == PC_WIDTH - 1) begin
                ff_scan <= 1'b0;
                ff_dir <= 1'b0;
            end else begin
                ff_sdi <= load[PC_WIDTH-2-i];
            end
        end
    endtask

    task automatic test_pause();
        logic [CNT_WIDTH-1:0] frozen;
        logic [PC_WIDTH-1:0]  pc_a;
        logic [PC_WIDTH-1:0]  pc_b;
        repeat (60) @(posedge host_clk);
        pause_target();
        wait_for(UNTIL_IDLE, 64'd0, 200);
        check_value("count", count, ticks_seen);
        frozen = count;
        scan_pass(1'b0, '0, pc_a);
        check_value("pc", 64'(pc_a), 64'(frozen[PC_WIDTH-1:0]));
        repeat (50) @(posedge host_clk);
        scan_pass(1'b0, '0, pc_b);
        check_value("pc", 64'(pc_b), 64'(pc_a));
        check_value("count", count, frozen);
        resume_target();
        repeat (2 * TICK_DIV) @(posedge host_clk);
        if (count == frozen) begin
            abort_run("count did not advance after resume");
        end
    endtask

    task automatic test_step();
        logic [CNT_WIDTH-1:0] pc_now;
        int                   pulses0;
        pause_target();
        pc_now = count;
        count_write <= 1'b1;
        count_wdata <= 64'h0123_4567_89ab_cdef;
        @(posedge host_clk);
        count_write <= 1'b0;
        step_write <= 1'b1;
        step_wdata <= 64'd13;
        @(posedge host_clk);
        step_write <= 1'b0;
        check_value("count", count, 64'h0123_4567_89ab_cdef);
        pulses0 = step_pulses;
        resume_target();
        wait_for(UNTIL_RUN, 64'd0, 200);
        repeat (2) @(posedge host_clk);
        check_value("step_trig pulses", 64'(step_pulses - pulses0), 64'd1);
        check_value("count", count, 64'h0123_4567_89ab_cdef + 64'd13);
        // put count back in step with the pc
        count_write <= 1'b1;
        count_wdata <= pc_now + 64'd13;
        @(posedge host_clk);
        count_write <= 1'b0;
    endtask

    task automatic test_breakpoint();
        logic [PC_WIDTH-1:0] pc_got;
        int                  pulses0;
        @(posedge host_clk);
        bp_val = count[PC_WIDTH-1:0] + 32'd40;
        bp_write <= 1'b1;
        bp_wdata <= bp_val;
        @(posedge host_clk);
        bp_write <= 1'b0;
        pulses0 = trig_pulses;
        resume_target();
        wait_for(UNTIL_RUN, 64'd0, 400);
        wait_for(UNTIL_IDLE, 64'd0, 200);
        check_value("trig pulses", 64'(trig_pulses - pulses0), 64'd1);
        scan_pass(1'b0, '0, pc_got);
        check_value("pc", 64'(pc_got), 64'(bp_val));
        check_value("count", count, 64'(bp_val));
    endtask

    task automatic test_scan();
        logic [PC_WIDTH-1:0] first;
        logic [PC_WIDTH-1:0] second;
        scan_pass(1'b0, '0, first);
        scan_pass(1'b0, '0, second);
        check_value("pc", 64'(first), 64'(count[PC_WIDTH-1:0]));
        check_value("pc", 64'(second), 64'(first));
        scan_pass(1'b1, 32'h0000_0a53, first);
        check_value("pc", 64'(first), 64'(bp_val));
        scan_pass(1'b0, '0, second);
        check_value("pc", 64'(second), 64'h0000_0a53);
        seq_base = 32'h0000_0a53 & ~32'd7;
        seq_rx = rx_count;
        pc_offset = 32'h0000_0a53 - count[PC_WIDTH-1:0];
        resume_target();
        wait_for(UNTIL_RX, rx_count + 1, 200);
    endtask

    task automatic test_console();
        logic [CNT_WIDTH-1:0] held;
        for (int i = 0; i < 400; i++) begin
            @(posedge host_clk);
            console_ready <= ($urandom % 3) != 0;
        end
        @(posedge host_clk);
        console_ready <= 1'b0;
        repeat (300) @(posedge host_clk);
        held = count;
        repeat (50) @(posedge host_clk);
        check_value("count", count, held);
        // a full buffer stops the target just before the next printing step
        check_value("pc", 64'(held[PC_WIDTH-1:0] + pc_offset),
                    64'(next_char_pc() + PC_WIDTH'((CONSOLE_DEPTH << CHAR_PERIOD_LOG2) - 1)));
        console_ready <= 1'b1;
        wait_for(UNTIL_RX, rx_count + 12, 1000);
        pause_target();
        wait_for(UNTIL_IDLE, 64'd0, 200);
        check_value("next char pc", 64'(next_char_pc()),
                    64'(((count[PC_WIDTH-1:0] + pc_offset) & ~32'd7) + 32'd8));
    endtask

    initial begin
        void'($urandom(35));
        host_rst = 1'b1;
        do_pause = 1'b0;
        do_resume = 1'b0;
        count_write = 1'b0;
        count_wdata = '0;
        step_write = 1'b0;
        step_wdata = '0;
        bp_write = 1'b0;
        bp_wdata = '0;
        ff_scan = 1'b0;
        ff_dir = 1'b0;
        ff_sdi = 1'b0;
        console_ready = 1'b1;
        seq_base = '0;
        seq_rx = '0;
        pc_offset = '0;
        repeat (5) @(posedge host_clk);
        host_rst <= 1'b0;
        test_pause();
        test_step();
        test_breakpoint();
        test_scan();
        test_console();
        if (dut.u_asserts.fails != 0) begin
            $display("%0d assertion failures", dut.u_asserts.fails);
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- verilog.f
design/emu_pkg.sv
design/tick_gen.sv
design/run_ctrl.sv
design/target_core.sv
design/console_fifo.sv
design/emu_top.sv
dv/emu_asserts.sv
dv/emu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= emu_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || { echo "run ended early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
